// ==== Bender.yml ====
package:
  name: riscv_data_cache

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_tag_store.sv
      - hdl/dcache_line_store.sv
      - hdl/dcache_ctrl_fsm.sv
      - hdl/dram_model.sv
      - hdl/riscv_data_cache.sv
  - target: test
    files:
      - testbench/tb_riscv_data_cache.sv

// ==== flist.f ====
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_line_store.sv
hdl/dcache_ctrl_fsm.sv
hdl/dram_model.sv
hdl/riscv_data_cache.sv
testbench/tb_riscv_data_cache.sv

// ==== hdl/dcache_ctrl_fsm.sv ====
`timescale 1ns/10ps

module dcache_ctrl_fsm (
  input  logic i_riscv_dcache_clk,
  input  logic i_rst,
  input  logic i_cpu_wren,
  input  logic i_cpu_rden,
  input  logic i_hit,
  input  logic i_dirty,
  input  logic i_mem_ready,
  output logic o_cache_rden,
  output logic o_cache_wren,
  output logic o_cache_insel,
  output logic o_mem_rden,
  output logic o_mem_wren,
  output logic o_set_dirty,
  output logic o_set_valid,
  output logic o_replace_tag,
  output logic o_stall,
  output logic o_tag_sel
);

  typedef enum logic [1:0] {
    IDLE      = 2'b00,
    WRITEBACK = 2'b01,
    REFILL    = 2'b10,
    UPDATE    = 2'b11
  } fsm_state_e;

  fsm_state_e state_q;
  fsm_state_e state_d;
  logic       cpu_req;

  assign cpu_req = i_cpu_rden || i_cpu_wren;

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    o_cache_rden  = 1'b0;
    o_cache_wren  = 1'b0;
    o_cache_insel = 1'b0;
    o_mem_rden    = 1'b0;
    o_mem_wren    = 1'b0;
    o_set_dirty   = 1'b0;
    o_set_valid   = 1'b0;
    o_replace_tag = 1'b0;
    o_stall       = 1'b0;
    o_tag_sel     = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (cpu_req && i_hit) begin
          o_cache_rden = i_cpu_rden;
          o_cache_wren = i_cpu_wren;
          o_set_dirty  = i_cpu_wren;
        end else if (cpu_req) begin
          o_stall = 1'b1;
          // memory strobe starts in the request cycle
          if (i_dirty) begin
            o_mem_wren   = 1'b1;
            o_tag_sel    = 1'b1;
            o_cache_rden = 1'b1;
            state_d      = WRITEBACK;
          end else begin
            o_mem_rden = 1'b1;
            state_d    = REFILL;
          end
        end
      end

      WRITEBACK: begin
        o_stall      = 1'b1;
        o_mem_wren   = 1'b1;
        o_tag_sel    = 1'b1;   // address the victim line
        o_cache_rden = 1'b1;
        if (i_mem_ready) state_d = REFILL;
      end

      REFILL: begin
        o_stall    = 1'b1;
        o_mem_rden = 1'b1;
        if (i_mem_ready) state_d = UPDATE;
      end

      default: begin  // UPDATE
        o_stall       = 1'b1;
        o_cache_wren  = 1'b1;
        o_cache_insel = 1'b1;
        o_replace_tag = 1'b1;
        o_set_valid   = 1'b1;
        state_d       = IDLE;   // retried request hits next
      end
    endcase
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // memory answers only a strobe that is still held
  mem_ready_on_strobe: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_rst)
    i_mem_ready |-> (o_mem_rden || o_mem_wren)
  ) else $error("memory ready with no strobe pending");

  cpu_strobes_exclusive: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_rst)
    !(i_cpu_rden && i_cpu_wren)
  ) else $error("cpu load and store strobes high together");

  // the held request must hit once the new line and tag are written
  refill_then_hit: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_rst)
    (state_q == UPDATE) |=> !o_stall
  ) else $error("request still stalled after refill");

endmodule

// ==== hdl/dcache_line_store.sv ====
`timescale 1ns/10ps

module dcache_line_store (
  input  logic                              i_riscv_dcache_clk,
  input  logic                              i_wren,
  input  logic                              i_rden,
  input  logic [dcache_pkg::INDEX-1:0]      i_index,
  input  logic [dcache_pkg::BYTE_OFF-1:0]   i_byte_offset,
  input  dcache_pkg::store_size_e           i_store_src,
  input  logic                              i_mem_in,
  input  logic [dcache_pkg::DATA_WIDTH-1:0] i_data_in,
  output logic [dcache_pkg::DATA_WIDTH-1:0] o_data_out
);

  import dcache_pkg::*;

  logic [DATA_WIDTH-1:0] line_mem [CACHE_DEPTH];

  logic [DATAPBLOCK-1:0] size_mask;   // bytes touched, before shifting
  logic [DATAPBLOCK-1:0] byte_mask;
  logic [DATA_WIDTH-1:0] cpu_wdata;
  logic                  store_aligned;

  //////////////////////////////////////////////////
  // store merge
  //////////////////////////////////////////////////

  always_comb begin
    unique case (i_store_src)
      STORE_BYTE: begin
        size_mask     = DATAPBLOCK'(16'h0001);
        store_aligned = 1'b1;
      end
      STORE_HALF: begin
        size_mask     = DATAPBLOCK'(16'h0003);
        store_aligned = (i_byte_offset[0] == 1'b0);
      end
      STORE_WORD: begin
        size_mask     = DATAPBLOCK'(16'h000f);
        store_aligned = (i_byte_offset[1:0] == 2'b00);
      end
      default: begin   // double
        size_mask     = DATAPBLOCK'(16'h00ff);
        store_aligned = (i_byte_offset[2:0] == 3'b000);
      end
    endcase
  end

  assign byte_mask = size_mask << i_byte_offset;
  assign cpu_wdata = i_data_in << {i_byte_offset, 3'b000};  // cpu data sits in the low bytes

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_wren) begin
      if (i_mem_in) begin
        line_mem[i_index] <= i_data_in;  // refill, whole line
      end else begin
        for (int b = 0; b < DATAPBLOCK; b++) begin
          if (byte_mask[b]) begin
            line_mem[i_index][b*8 +: 8] <= cpu_wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // read port, also feeds writeback data to memory
  assign o_data_out = i_rden ? line_mem[i_index] : '0;

  // core never splits an access across a natural boundary
  store_natural_align: assert property (
    @(posedge i_riscv_dcache_clk)
    (i_wren && !i_mem_in) |-> store_aligned
  ) else $error("misaligned store, offset %0d size %s", i_byte_offset, i_store_src.name());

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  localparam int DATA_WIDTH  = 128;                       // bits per line
  localparam int DATAPBLOCK  = 16;                        // bytes per line
  localparam int CACHE_SIZE  = 1024;                      // bytes
  localparam int CACHE_DEPTH = CACHE_SIZE / DATAPBLOCK;   // 64 lines

  // main memory
  localparam int MEM_SIZE    = 8192;                      // bytes
  localparam int MEM_DEPTH   = MEM_SIZE / DATAPBLOCK;     // 512 lines

  // address split, low bits of the physical address only
  localparam int ADDR        = $clog2(MEM_SIZE);          // 13
  localparam int BYTE_OFF    = $clog2(DATAPBLOCK);        // 4
  localparam int INDEX       = $clog2(CACHE_DEPTH);       // 6
  localparam int TAG         = ADDR - BYTE_OFF - INDEX;   // 3

  //////////////////////////////////////////////////
  // memory timing
  //////////////////////////////////////////////////

  // strobe rise to ready pulse
  localparam int MEM_LATENCY = 4;
  localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

  //////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////

  // field order matches the physical address, msb first
  typedef struct packed {
    logic [TAG-1:0]      tag;
    logic [INDEX-1:0]    index;
    logic [BYTE_OFF-1:0] byte_offset;
  } dcache_addr_t;

  // store width, same code the core puts on store_src
  typedef enum logic [1:0] {
    STORE_BYTE   = 2'b00,
    STORE_HALF   = 2'b01,
    STORE_WORD   = 2'b10,
    STORE_DOUBLE = 2'b11
  } store_size_e;

endpackage

// ==== hdl/dcache_tag_store.sv ====
`timescale 1ns/10ps

module dcache_tag_store (
  input  logic                       i_riscv_dcache_clk,
  input  logic                       i_rst,
  input  logic [dcache_pkg::INDEX-1:0] i_index,
  input  logic [dcache_pkg::TAG-1:0] i_tag,
  input  logic                       i_set_dirty,
  input  logic                       i_set_valid,
  input  logic                       i_replace_tag,
  output logic                       o_hit,
  output logic                       o_dirty,
  output logic [dcache_pkg::TAG-1:0] o_tag_old
);

  import dcache_pkg::*;

  logic [TAG-1:0]         tag_mem [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid_q;
  logic [CACHE_DEPTH-1:0] dirty_q;

  //////////////////////////////////////////////////
  // status bits
  //////////////////////////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (i_replace_tag) begin
      valid_q[i_index] <= i_set_valid;
      dirty_q[i_index] <= 1'b0;  // fresh line from memory is clean
    end else if (i_set_dirty) begin
      dirty_q[i_index] <= 1'b1;  // store hit
    end
  end

  // tag array, only meaningful where valid is set
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_replace_tag) begin
      tag_mem[i_index] <= i_tag;
    end
  end

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  assign o_tag_old = tag_mem[i_index];  // victim tag for writeback
  assign o_hit     = valid_q[i_index] && (tag_mem[i_index] == i_tag);
  assign o_dirty   = dirty_q[i_index];

  // the controller only marks lines that the tag compare accepted
  dirty_only_on_hit: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_rst)
    i_set_dirty |-> o_hit
  ) else $error("dirty bit set on a line that misses");

endmodule

// ==== hdl/dram_model.sv ====
`timescale 1ns/10ps

module dram_model (
  input  logic                                      i_riscv_dcache_clk,
  input  logic                                      i_rst,
  input  logic                                      i_wren,
  input  logic                                      i_rden,
  input  logic [dcache_pkg::INDEX+dcache_pkg::TAG-1:0] i_addr,
  input  logic [dcache_pkg::DATA_WIDTH-1:0]         i_data_in,
  output logic [dcache_pkg::DATA_WIDTH-1:0]         o_data_out,
  output logic                                      o_mem_ready
);

  import dcache_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
  logic [LAT_CNT_W-1:0]  lat_cnt_q;
  logic                  busy;

  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign busy = (i_rden || i_wren) && !o_mem_ready;

  //////////////////////////////////////////////////
  // latency counter and ready pulse
  //////////////////////////////////////////////////

  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_rst) begin
      lat_cnt_q   <= '0;
      o_mem_ready <= 1'b0;
    end else begin
      o_mem_ready <= 1'b0;   // single cycle pulse
      if (busy) begin
        if (lat_cnt_q == LAT_CNT_W'(MEM_LATENCY - 1)) begin
          lat_cnt_q   <= '0;
          o_mem_ready <= 1'b1;
        end else begin
          lat_cnt_q <= lat_cnt_q + 1'b1;
        end
      end
    end
  end

  // read data lands with ready and holds until the next read
  always_ff @(posedge i_riscv_dcache_clk) begin
    if (i_rden && busy && lat_cnt_q == LAT_CNT_W'(MEM_LATENCY - 1)) begin
      o_data_out <= mem[i_addr];
    end
    if (i_wren && o_mem_ready) begin
      mem[i_addr] <= i_data_in;
    end
  end

  strobe_held_to_ready: assert property (
    @(posedge i_riscv_dcache_clk) disable iff (i_rst)
    busy |=> ({i_rden, i_wren} == $past({i_rden, i_wren}))
  ) else $error("memory strobe dropped before ready");

endmodule

// ==== hdl/riscv_data_cache.sv ====
`timescale 1ns/10ps

module riscv_data_cache (
  input  logic                    i_riscv_dcache_clk,
  input  logic                    i_rst,
  input  logic                    i_riscv_dcache_cpu_wren,
  input  logic                    i_riscv_dcache_cpu_rden,
  input  dcache_pkg::store_size_e i_riscv_dcache_store_src,
  input  logic [63:0]             i_riscv_dcache_phys_addr,
  input  logic [63:0]             i_riscv_dcache_cpu_data_in,
  output logic [63:0]             o_riscv_dcache_cpu_data_out,
  output logic                    o_riscv_dcache_cpu_stall
);

  import dcache_pkg::*;

  dcache_addr_t addr;   // only the low ADDR bits reach memory

  // controller
  logic fsm_cache_rden;
  logic fsm_cache_wren;
  logic fsm_cache_insel;
  logic fsm_mem_rden;
  logic fsm_mem_wren;
  logic fsm_set_dirty;
  logic fsm_set_valid;
  logic fsm_replace_tag;
  logic fsm_tag_sel;

  // tag store
  logic           tag_hit;
  logic           tag_dirty;
  logic [TAG-1:0] tag_old;

  // data paths
  logic [DATA_WIDTH-1:0] cache_data_in;
  logic [DATA_WIDTH-1:0] cache_data_out;
  logic [INDEX+TAG-1:0]  mem_addr;
  logic                  mem_ready;
  logic [DATA_WIDTH-1:0] mem_data_out;

  //////////////////////////////////////////////////
  // address split and steering
  //////////////////////////////////////////////////

  assign addr     = dcache_addr_t'(i_riscv_dcache_phys_addr[ADDR-1:0]);
  assign mem_addr = fsm_tag_sel ? {tag_old, addr.index}    // writeback of the victim
                                : {addr.tag, addr.index};

  assign cache_data_in = fsm_cache_insel ? mem_data_out
                                         : {{(DATA_WIDTH-64){1'b0}}, i_riscv_dcache_cpu_data_in};

  // bit 3 picks the doubleword within the line
  assign o_riscv_dcache_cpu_data_out = addr.byte_offset[BYTE_OFF-1] ? cache_data_out[127:64]
                                                                     : cache_data_out[63:0];

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  dcache_tag_store u_tag_store (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst              (i_rst),
    .i_index            (addr.index),
    .i_tag              (addr.tag),
    .i_set_dirty        (fsm_set_dirty),
    .i_set_valid        (fsm_set_valid),
    .i_replace_tag      (fsm_replace_tag),
    .o_hit              (tag_hit),
    .o_dirty            (tag_dirty),
    .o_tag_old          (tag_old)
  );

  dcache_line_store u_line_store (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_wren             (fsm_cache_wren),
    .i_rden             (fsm_cache_rden),
    .i_index            (addr.index),
    .i_byte_offset      (addr.byte_offset),
    .i_store_src        (i_riscv_dcache_store_src),
    .i_mem_in           (fsm_cache_insel),
    .i_data_in          (cache_data_in),
    .o_data_out         (cache_data_out)
  );

  dcache_ctrl_fsm u_ctrl_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst              (i_rst),
    .i_cpu_wren         (i_riscv_dcache_cpu_wren),
    .i_cpu_rden         (i_riscv_dcache_cpu_rden),
    .i_hit              (tag_hit),
    .i_dirty            (tag_dirty),
    .i_mem_ready        (mem_ready),
    .o_cache_rden       (fsm_cache_rden),
    .o_cache_wren       (fsm_cache_wren),
    .o_cache_insel      (fsm_cache_insel),
    .o_mem_rden         (fsm_mem_rden),
    .o_mem_wren         (fsm_mem_wren),
    .o_set_dirty        (fsm_set_dirty),
    .o_set_valid        (fsm_set_valid),
    .o_replace_tag      (fsm_replace_tag),
    .o_stall            (o_riscv_dcache_cpu_stall),
    .o_tag_sel          (fsm_tag_sel)
  );

  dram_model u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_rst              (i_rst),
    .i_wren             (fsm_mem_wren),
    .i_rden             (fsm_mem_rden),
    .i_addr             (mem_addr),
    .i_data_in          (cache_data_out),   // victim line straight from the line store
    .o_data_out         (mem_data_out),
    .o_mem_ready        (mem_ready)
  );

endmodule

// ==== testbench/tb_riscv_data_cache.sv ====
`timescale 1ns/10ps

module tb_riscv_data_cache;

  import dcache_pkg::*;

  localparam int          CLK_PERIOD  = 40;          // ns
  localparam int          RST_CYCLES  = 16;
  localparam int          TIMEOUT_CYC = 50;
  localparam int          N_RANDOM    = 300;
  localparam logic [31:0] SEED        = 32'h0dc642ec;

  // what the stall assertions expect of the current request
  localparam int KIND_ANY  = 0;
  localparam int KIND_HIT  = 1;
  localparam int KIND_MISS = 2;

  logic        clk;
  logic        rst;
  logic        cpu_wren;
  logic        cpu_rden;
  store_size_e store_src;
  logic [63:0] phys_addr;
  logic [63:0] cpu_data_in;
  logic [63:0] cpu_data_out;
  logic        cpu_stall;
  logic        cpu_req;

  logic [7:0]  ref_mem [MEM_SIZE];   // byte image of main memory
  logic [63:0] exp_data;
  logic        expect_hit;
  logic        expect_miss;
  logic        timed_out;
  string       test_name;
  int          err_cnt;
  int          test_cnt;
  int          test_fail_cnt;
  int          test_err_start;
  int          access_cnt;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  riscv_data_cache riscv_data_cache_i (
    .i_riscv_dcache_clk          (clk),
    .i_rst                       (rst),
    .i_riscv_dcache_cpu_wren     (cpu_wren),
    .i_riscv_dcache_cpu_rden     (cpu_rden),
    .i_riscv_dcache_store_src    (store_src),
    .i_riscv_dcache_phys_addr    (phys_addr),
    .i_riscv_dcache_cpu_data_in  (cpu_data_in),
    .o_riscv_dcache_cpu_data_out (cpu_data_out),
    .o_riscv_dcache_cpu_stall    (cpu_stall)
  );

  assign cpu_req = cpu_rden || cpu_wren;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  load_data_check: assert property (
    @(posedge clk) disable iff (rst)
    (cpu_rden && !cpu_stall) |-> (cpu_data_out == exp_data)
  ) else begin
    $display("** Error %s: load 0x%04h expected %016h actual %016h", test_name,
             $sampled(phys_addr[ADDR-1:0]), $sampled(exp_data), $sampled(cpu_data_out));
    err_cnt++;
  end

  idle_stall_check: assert property (
    @(posedge clk) disable iff (rst)
    !cpu_req |-> !cpu_stall
  ) else begin
    $display("%s: stall is high while no request is pending", test_name);
    err_cnt++;
  end

  hit_stall_check: assert property (
    @(posedge clk) disable iff (rst)
    (expect_hit && cpu_req) |-> !cpu_stall
  ) else begin
    $display("%s: request to a filled line stalled", test_name);
    err_cnt++;
  end

  // a miss must stall in its very first cycle
  miss_stall_check: assert property (
    @(posedge clk) disable iff (rst)
    (expect_miss && $rose(cpu_req)) |-> cpu_stall
  ) else begin
    $display("%s: miss did not stall in the request cycle", test_name);
    err_cnt++;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [63:0] model_dword(input logic [ADDR-1:0] a);
    logic [63:0] d;
    for (int i = 0; i < 8; i++) begin
      d[i*8 +: 8] = ref_mem[{a[ADDR-1:3], 3'b000} + i];
    end
    return d;
  endfunction

  // low bytes of the data land at the byte address
  function automatic void apply_store(input logic [ADDR-1:0] a, input store_size_e sz,
                                      input logic [63:0] d);
    int n;
    n = 1 << int'(sz);
    for (int i = 0; i < n; i++) begin
      ref_mem[a + i] = d[i*8 +: 8];
    end
  endfunction

  function automatic logic [ADDR-1:0] align_to_size(input logic [ADDR-1:0] a,
                                                    input store_size_e sz);
    return a & ~ADDR'((1 << int'(sz)) - 1);
  endfunction

  //////////////////////////////////////////////////
  // bus driver and bookkeeping
  //////////////////////////////////////////////////

  task automatic access(input logic wr, input logic [ADDR-1:0] a, input store_size_e sz,
                        input logic [63:0] d, input int kind);
    int cycles;
    @(negedge clk);
    phys_addr   = 64'(a);
    store_src   = sz;
    cpu_data_in = d;
    exp_data    = model_dword(a);
    expect_hit  = (kind == KIND_HIT);
    expect_miss = (kind == KIND_MISS);
    cpu_wren    = wr;
    cpu_rden    = !wr;
    access_cnt++;
    cycles = 0;
    #(CLK_PERIOD/4);   // stall settled, rising edge still ahead
    while (cpu_stall && cycles < TIMEOUT_CYC) begin
      @(negedge clk);
      #(CLK_PERIOD/4);
      cycles++;
    end
    if (cpu_stall) begin
      $display("%s: stall still high after %0d cycles at address 0x%04h",
               test_name, TIMEOUT_CYC, a);
      timed_out = 1'b1;
      forever @(negedge clk);   // watchdog process ends the run
    end else begin
      @(posedge clk);           // request completes on this edge
      if (wr) apply_store(a, sz, d);
      @(negedge clk);
      cpu_wren    = 1'b0;
      cpu_rden    = 1'b0;
      expect_hit  = 1'b0;
      expect_miss = 1'b0;
    end
  endtask

  task automatic open_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
    access_cnt     = 0;
  endtask

  task automatic close_test();
    int errs;
    errs = err_cnt - test_err_start;
    test_cnt++;
    if (errs != 0) test_fail_cnt++;
    $display("[%0d] %-16s %4d accesses  %0d errors  %s", test_cnt, test_name,
             access_cnt, errs, (errs == 0) ? "ok" : "FAIL");
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d failing, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0 && test_fail_cnt == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic cold_read_seq();
    open_test("cold_read");
    repeat (4) @(negedge clk);   // idle cycles, stall must stay low
    access(1'b0, 13'h0a38, STORE_DOUBLE, '0, KIND_MISS);
    access(1'b0, 13'h1f70, STORE_DOUBLE, '0, KIND_MISS);
    close_test();
  endtask

  task automatic store_size_sweep();
    logic [ADDR-1:0] base;
    int              n;
    base = 13'h0240;
    open_test("store_sizes");
    for (int s = 0; s < 4; s++) begin
      n = 1 << s;
      for (int off = 0; off < DATAPBLOCK; off += n) begin
        access(1'b1, base + ADDR'(off), store_size_e'(s), {$urandom, $urandom}, KIND_ANY);
        access(1'b0, base, STORE_DOUBLE, '0, KIND_HIT);
        access(1'b0, base + 13'd8, STORE_DOUBLE, '0, KIND_HIT);
      end
    end
    close_test();
  endtask

  task automatic hit_sequence();
    open_test("hits");
    access(1'b0, 13'h0400, STORE_DOUBLE, '0, KIND_MISS);
    access(1'b0, 13'h0408, STORE_DOUBLE, '0, KIND_HIT);
    access(1'b1, 13'h0404, STORE_WORD, 64'h0000_0000_a5c3_9e71, KIND_HIT);
    access(1'b0, 13'h0400, STORE_DOUBLE, '0, KIND_HIT);
    access(1'b1, 13'h040e, STORE_HALF, 64'h0000_0000_0000_7e81, KIND_HIT);
    access(1'b0, 13'h0408, STORE_DOUBLE, '0, KIND_HIT);
    close_test();
  endtask

  // a and b share index 16, tags differ
  task automatic dirty_eviction();
    logic [ADDR-1:0] a;
    logic [ADDR-1:0] b;
    a = 13'h0100;
    b = a + 13'h0400;
    open_test("dirty_eviction");
    access(1'b1, a, STORE_DOUBLE, 64'hfeed_c0de_1357_9bdf, KIND_ANY);
    access(1'b1, a + 13'd8, STORE_WORD, 64'h0000_0000_2468_ace0, KIND_HIT);
    access(1'b0, b, STORE_DOUBLE, '0, KIND_MISS);     // writes a back
    access(1'b1, b + 13'd4, STORE_WORD, 64'h0000_0000_5a5a_0ff0, KIND_HIT);
    access(1'b0, a, STORE_DOUBLE, '0, KIND_MISS);     // writes b back, refills a
    access(1'b0, a + 13'd8, STORE_DOUBLE, '0, KIND_HIT);
    access(1'b0, b, STORE_DOUBLE, '0, KIND_MISS);
    close_test();
  endtask

  task automatic random_traffic();
    logic            wr;
    store_size_e     sz;
    logic [ADDR-1:0] a;
    open_test("random_traffic");
    for (int k = 0; k < N_RANDOM; k++) begin
      wr = 1'($urandom_range(0, 1));
      sz = store_size_e'($urandom_range(0, 3));
      a  = align_to_size(ADDR'($urandom), sz);
      access(wr, a, sz, {$urandom, $urandom}, KIND_ANY);
    end
    close_test();
  endtask

  initial begin
    wait (timed_out);
    finish_run();
  end

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    cpu_wren      = 1'b0;
    cpu_rden      = 1'b0;
    store_src     = STORE_DOUBLE;
    phys_addr     = '0;
    cpu_data_in   = '0;
    exp_data      = '0;
    expect_hit    = 1'b0;
    expect_miss   = 1'b0;
    timed_out     = 1'b0;
    test_name     = "reset";
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    access_cnt    = 0;
    for (int i = 0; i < MEM_SIZE; i++) begin
      ref_mem[i] = 8'h00;
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    cold_read_seq();
    store_size_sweep();
    hit_sequence();
    dirty_eviction();
    random_traffic();
    finish_run();
  end

endmodule
